//--- files.f
+incdir+dv
source/rvIsaPkg.sv
source/lsqPkg.sv
source/lsqDispatch.sv
source/lsqEntry.sv
source/lsqIssue.sv
source/dataCache.sv
source/loadStoreBuffer.sv
dv/tbLoadStoreBuffer.sv

//--- dv/tbVectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// each row holds kind, op, tag, rs1 ready, rs1 tag, base, imm, data, random data and wait cycles
// data is store data, broadcast value or the expected full flag
typedef enum logic [2:0] {
    DoDispatch, DoCommit, DoBroadcast, DoFlush, WaitLoad, WaitQuiet, CheckFullFlag
} stepKindT;

typedef struct packed {
    stepKindT    kind;
    memOpT       op;
    tagT         tag;
    logic        rs1Ready;
    tagT         rs1Tag;
    logic [31:0] base;
    logic [31:0] imm;
    logic [31:0] data;
    logic        randomData;
    logic [7:0]  waitCycles;
} stepT;

localparam int NumSteps = 55;

localparam stepT Steps [NumSteps] = '{
    // one store of each size followed by every load type
    '{DoDispatch,    SW,    3'd0, 1'b1, 3'd0, 32'h100, 32'h00, 32'h0000_0000, 1'b1, 8'd0},
    '{DoCommit,      OTHER, 3'd0, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd2},
    '{DoDispatch,    SH,    3'd1, 1'b1, 3'd0, 32'h100, 32'h0A, 32'h0000_80f1, 1'b0, 8'd0},
    '{DoCommit,      OTHER, 3'd1, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd2},
    '{DoDispatch,    SB,    3'd2, 1'b1, 3'd0, 32'h100, 32'h0D, 32'h0000_009c, 1'b0, 8'd0},
    '{DoCommit,      OTHER, 3'd2, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd2},
    '{DoDispatch,    SW,    3'd3, 1'b1, 3'd0, 32'h100, 32'h20, 32'h0000_0108, 1'b0, 8'd0},
    '{DoCommit,      OTHER, 3'd3, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd2},
    '{DoDispatch,    LW,    3'd0, 1'b1, 3'd0, 32'h100, 32'h00, 32'h0000_0000, 1'b0, 8'd0},
    '{DoDispatch,    LH,    3'd1, 1'b1, 3'd0, 32'h100, 32'h0A, 32'h0000_0000, 1'b0, 8'd0},
    '{DoDispatch,    LHU,   3'd2, 1'b1, 3'd0, 32'h100, 32'h0A, 32'h0000_0000, 1'b0, 8'd0},
    '{DoDispatch,    LB,    3'd3, 1'b1, 3'd0, 32'h100, 32'h0D, 32'h0000_0000, 1'b0, 8'd0},
    '{DoDispatch,    LBU,   3'd4, 1'b1, 3'd0, 32'h100, 32'h0D, 32'h0000_0000, 1'b0, 8'd0},
    '{WaitLoad,      OTHER, 3'd0, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd8},
    '{WaitLoad,      OTHER, 3'd1, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd8},
    '{WaitLoad,      OTHER, 3'd2, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd8},
    '{WaitLoad,      OTHER, 3'd3, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd8},
    '{WaitLoad,      OTHER, 3'd4, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd8},
    // base waits on an execute result
    '{DoDispatch,    LW,    3'd0, 1'b0, 3'd5, 32'h000, 32'h04, 32'h0000_0000, 1'b0, 8'd0},
    '{WaitQuiet,     OTHER, 3'd0, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd6},
    '{DoBroadcast,   OTHER, 3'd5, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_00fc, 1'b0, 8'd0},
    '{WaitLoad,      OTHER, 3'd0, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd8},
    // base comes from another load
    '{DoDispatch,    LH,    3'd2, 1'b0, 3'd3, 32'h000, 32'h02, 32'h0000_0000, 1'b0, 8'd0},
    '{DoDispatch,    LW,    3'd3, 1'b1, 3'd0, 32'h100, 32'h20, 32'h0000_0000, 1'b0, 8'd0},
    '{WaitLoad,      OTHER, 3'd3, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd8},
    '{WaitLoad,      OTHER, 3'd2, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd8},
    // fill every slot while a non-memory op takes none
    '{DoDispatch,    OTHER, 3'd7, 1'b1, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd0},
    '{DoDispatch,    LW,    3'd0, 1'b0, 3'd6, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd0},
    '{DoDispatch,    LW,    3'd1, 1'b0, 3'd6, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd0},
    '{DoDispatch,    LW,    3'd2, 1'b0, 3'd6, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd0},
    '{DoDispatch,    LW,    3'd3, 1'b0, 3'd6, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd0},
    '{DoDispatch,    LW,    3'd4, 1'b0, 3'd6, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd0},
    '{DoDispatch,    LW,    3'd5, 1'b0, 3'd6, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd0},
    '{DoDispatch,    LW,    3'd6, 1'b0, 3'd6, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd0},
    '{CheckFullFlag, OTHER, 3'd0, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd0},
    '{DoDispatch,    LW,    3'd7, 1'b0, 3'd7, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd0},
    '{CheckFullFlag, OTHER, 3'd0, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0001, 1'b0, 8'd0},
    '{DoBroadcast,   OTHER, 3'd7, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0100, 1'b0, 8'd0},
    '{WaitLoad,      OTHER, 3'd7, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd8},
    '{CheckFullFlag, OTHER, 3'd0, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd0},
    // a committed store hands its slot back
    '{DoDispatch,    SB,    3'd7, 1'b1, 3'd0, 32'h100, 32'h40, 32'h0000_005a, 1'b0, 8'd0},
    '{CheckFullFlag, OTHER, 3'd0, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0001, 1'b0, 8'd0},
    '{DoCommit,      OTHER, 3'd7, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd2},
    '{CheckFullFlag, OTHER, 3'd0, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd0},
    // flush drops waiting loads and one already sent to the cache
    '{DoDispatch,    LB,    3'd7, 1'b1, 3'd0, 32'h100, 32'h0D, 32'h0000_0000, 1'b0, 8'd0},
    '{DoFlush,       OTHER, 3'd0, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd1},
    '{DoBroadcast,   OTHER, 3'd6, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0100, 1'b0, 8'd0},
    '{WaitQuiet,     OTHER, 3'd0, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd8},
    '{DoDispatch,    LW,    3'd1, 1'b1, 3'd0, 32'h100, 32'h00, 32'h0000_0000, 1'b0, 8'd0},
    '{WaitLoad,      OTHER, 3'd1, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd8},
    // committed store is silent and its tag comes back
    '{DoDispatch,    SB,    3'd4, 1'b1, 3'd0, 32'h100, 32'h30, 32'h0000_0000, 1'b1, 8'd0},
    '{DoCommit,      OTHER, 3'd4, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd2},
    '{WaitQuiet,     OTHER, 3'd0, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd4},
    '{DoDispatch,    LBU,   3'd4, 1'b1, 3'd0, 32'h100, 32'h30, 32'h0000_0000, 1'b0, 8'd0},
    '{WaitLoad,      OTHER, 3'd4, 1'b0, 3'd0, 32'h000, 32'h00, 32'h0000_0000, 1'b0, 8'd8}
};

`endif

//--- dv/tbLoadStoreBuffer.sv
`timescale 1ns/1ps

module tbLoadStoreBuffer
    import rvIsaPkg::*, lsqPkg::*;
();

    localparam int ClkPeriod  = 4;
    localparam int CacheDepth = 1024;

    `include "tbVectors.svh"

    logic      clk;
    logic      rst;
    logic      flush;
    dispatchT  dispatch;
    broadcastT exBroadcast;
    logic      commitValid;
    tagT       commitTag;
    logic      full;
    broadcastT loadResult;

    integer    seed;
    broadcastT resultQ [$];

    // reference memory and what each tag holds
    logic [7:0]  refMem [CacheDepth];
    logic        pendValid [NumEntries];
    memOpT       pendOp [NumEntries];
    logic [31:0] pendImm [NumEntries];
    logic        baseReady [NumEntries];
    tagT         baseTag [NumEntries];
    logic [31:0] baseVal [NumEntries];
    logic [31:0] stData [NumEntries];

    loadStoreBuffer #(.NumEntries(NumEntries), .CacheDepth(CacheDepth)) i_dut (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .dispatch   (dispatch),
        .exBroadcast(exBroadcast),
        .commitValid(commitValid),
        .commitTag  (commitTag),
        .full       (full),
        .loadResult (loadResult)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // sampled mid-cycle, well away from the driving edge
    always @(negedge clk) begin
        if (!rst && loadResult.valid) begin
            resultQ.push_back(loadResult);
        end
    end

    task automatic reportFailure(string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic checkResult(broadcastT got, broadcastT exp);
        if (got !== exp) begin
            reportFailure($sformatf("ERROR %0t ns loadResult expected %0d/%08h got %0d/%08h",
                $time, exp.tag, exp.value, got.tag, got.value));
        end
    endtask

    task automatic checkFull(logic got, logic exp);
        if (got !== exp) begin
            reportFailure($sformatf("ERROR %0t ns full expected %0b got %0b", $time, exp, got));
        end
    endtask

    function automatic int memIndex(logic [31:0] addr, int offset);
        return int'((addr + 32'(offset)) % CacheDepth);
    endfunction

    // little endian, narrow loads extend from their top byte
    function automatic logic [31:0] refLoad(memOpT op, logic [31:0] addr);
        logic [31:0] w;
        w = {refMem[memIndex(addr, 3)], refMem[memIndex(addr, 2)],
             refMem[memIndex(addr, 1)], refMem[memIndex(addr, 0)]};
        case (op)
            LB:      return {{24{w[7]}}, w[7:0]};
            LBU:     return {24'h0, w[7:0]};
            LH:      return {{16{w[15]}}, w[15:0]};
            LHU:     return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic refStore(memOpT op, logic [31:0] addr, logic [31:0] data);
        refMem[memIndex(addr, 0)] = data[7:0];
        if (op != SB) begin
            refMem[memIndex(addr, 1)] = data[15:8];
        end
        if (op == SW) begin
            refMem[memIndex(addr, 2)] = data[23:16];
            refMem[memIndex(addr, 3)] = data[31:24];
        end
    endtask

    task automatic wakeWaiters(tagT t, logic [31:0] value);
        for (int i = 0; i < NumEntries; i++) begin
            if (pendValid[i] && !baseReady[i] && baseTag[i] == t) begin
                baseReady[i] = 1'b1;
                baseVal[i]   = value;
            end
        end
    endtask

    task automatic expectLoad(tagT t, int limit);
        broadcastT got;
        broadcastT exp;
        int        waited;
        waited = 0;
        while (resultQ.size() == 0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (resultQ.size() == 0) begin
            reportFailure($sformatf("no load result for tag %0d within %0d cycles", t, limit));
        end
        if (!pendValid[t] || !baseReady[t]) begin
            reportFailure($sformatf("tag %0d holds no load with a known base", t));
        end
        got = resultQ.pop_front();
        exp = '{valid: 1'b1, tag: t, value: refLoad(pendOp[t], baseVal[t] + pendImm[t])};
        checkResult(got, exp);
        pendValid[t] = 1'b0;
        wakeWaiters(t, exp.value);
    endtask

    task automatic runStep(stepT s);
        dispatchT    d;
        logic [31:0] data;
        data = s.randomData ? $random(seed) : s.data;
        case (s.kind)
            DoDispatch: begin
                d       = '0;
                d.valid = 1'b1;
                d.op    = s.op;
                d.imm   = s.imm;
                d.rdTag = s.tag;
                d.rs1   = '{ready: s.rs1Ready, tag: s.rs1Tag, value: s.base};
                d.rs2   = '{ready: 1'b1, tag: tagT'(0), value: data};
                if (s.op != OTHER) begin
                    pendValid[s.tag] = 1'b1;
                    pendOp[s.tag]    = s.op;
                    pendImm[s.tag]   = s.imm;
                    baseReady[s.tag] = s.rs1Ready;
                    baseTag[s.tag]   = s.rs1Tag;
                    baseVal[s.tag]   = s.base;
                    stData[s.tag]    = data;
                end
                @(posedge clk);
                dispatch <= d;
                @(posedge clk);
                dispatch <= '0;
            end
            DoCommit: begin
                @(posedge clk);
                commitValid <= 1'b1;
                commitTag   <= s.tag;
                @(posedge clk);
                commitValid <= 1'b0;
                refStore(pendOp[s.tag], baseVal[s.tag] + pendImm[s.tag], stData[s.tag]);
                pendValid[s.tag] = 1'b0;
            end
            DoBroadcast: begin
                @(posedge clk);
                exBroadcast <= '{valid: 1'b1, tag: s.tag, value: data};
                @(posedge clk);
                exBroadcast <= '0;
                wakeWaiters(s.tag, data);
            end
            DoFlush: begin
                @(posedge clk);
                flush <= 1'b1;
                @(posedge clk);
                flush <= 1'b0;
                for (int i = 0; i < NumEntries; i++) begin
                    pendValid[i] = 1'b0;
                end
            end
            WaitLoad: expectLoad(s.tag, int'(s.waitCycles));
            WaitQuiet: begin
                repeat (s.waitCycles) @(negedge clk);
                if (resultQ.size() != 0) begin
                    reportFailure($sformatf("unexpected load result for tag %0d at %0t ns",
                        resultQ[0].tag, $time));
                end
            end
            default: begin
                @(negedge clk);
                checkFull(full, s.data[0]);
            end
        endcase
        if (s.kind inside {DoDispatch, DoCommit, DoBroadcast, DoFlush}) begin
            repeat (s.waitCycles) @(posedge clk);
        end
    endtask

    initial begin
        seed        = 32'h04c7_6497;
        clk         = 1'b0;
        rst         = 1'b1;
        flush       = 1'b0;
        dispatch    = '0;
        exBroadcast = '0;
        commitValid = 1'b0;
        commitTag   = '0;
        for (int i = 0; i < NumEntries; i++) begin
            pendValid[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < NumSteps; i++) begin
            runStep(Steps[i]);
        end
        repeat (6) @(negedge clk);
        if (resultQ.size() != 0) begin
            reportFailure("load results left over after the last step");
        end else begin
            $display("test passed");
            $finish;
        end
    end

    // bound from the table, each step is at most its wait plus a few cycles
    initial begin
        int maxWait;
        int limit;
        maxWait = 0;
        for (int i = 0; i < NumSteps; i++) begin
            if (int'(Steps[i].waitCycles) > maxWait) begin
                maxWait = int'(Steps[i].waitCycles);
            end
        end
        limit = (NumSteps * (maxWait + 4) + 20) * ClkPeriod;
        #(limit);
        reportFailure($sformatf("watchdog timeout, run still busy after %0d ns", limit));
    end

endmodule

//--- source/loadStoreBuffer.sv
`timescale 1ns/1ps

module loadStoreBuffer
    import lsqPkg::*;
#(
    parameter int NumEntries = lsqPkg::NumEntries,
    parameter int CacheDepth = 1024
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  dispatchT  dispatch,
    input  broadcastT exBroadcast,
    input  logic      commitValid,
    input  tagT       commitTag,
    output logic      full,
    output broadcastT loadResult
);

    logic [NumEntries-1:0] writeEn;
    logic [NumEntries-1:0] occupiedVec;
    logic [NumEntries-1:0] grant;
    logic [NumEntries-1:0] freeVec;
    dispatchT              entryIn;
    entryStateT            states [NumEntries];
    memReqT                memReq;
    memRespT               memResp;

    lsqDispatch #(.NumEntries(NumEntries)) uDispatch (
        .clk        (clk),
        .rst        (rst),
        .dispatch   (dispatch),
        .occupiedVec(occupiedVec),
        .writeEn    (writeEn),
        .entryIn    (entryIn),
        .full       (full)
    );

    for (genvar i = 0; i < NumEntries; i++) begin : gEntry
        // any response, load or store, retires its slot
        assign freeVec[i]     = memResp.valid && memResp.tag == tagT'(i);
        assign occupiedVec[i] = states[i].occupied;

        lsqEntry uEntry (
            .clk        (clk),
            .rst        (rst),
            .flush      (flush),
            .writeEn    (writeEn[i]),
            .issueGrant (grant[i]),
            .free       (freeVec[i]),
            .entryIn    (entryIn),
            .exBroadcast(exBroadcast),
            .loadResult (loadResult),
            .state      (states[i])
        );
    end

    lsqIssue #(.NumEntries(NumEntries)) uIssue (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .states     (states),
        .commitValid(commitValid),
        .commitTag  (commitTag),
        .grant      (grant),
        .memReq     (memReq)
    );

    dataCache #(.Depth(CacheDepth)) uCache (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .memReq (memReq),
        .memResp(memResp)
    );

    // a response arriving in the flush cycle is dropped too
    assign loadResult = '{
        valid: memResp.valid && !memResp.isStore && !flush,
        tag:   memResp.tag,
        value: memResp.data
    };

endmodule

//--- source/dataCache.sv
`timescale 1ns/1ps

module dataCache
    import rvIsaPkg::*, lsqPkg::*;
#(
    parameter int Depth = 1024
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    input  memReqT  memReq,
    output memRespT memResp
);

    localparam int IdxWidth = $clog2(Depth);

    logic [7:0]           mem [Depth];
    logic [IdxWidth-1:0]  idx;
    logic [7:0]           b0;
    logic [7:0]           b1;
    logic [7:0]           b2;
    logic [7:0]           b3;
    logic [DataWidth-1:0] loadValue;

    assign idx = memReq.addr[IdxWidth-1:0];

    // little endian, byte 0 at the lowest address
    assign b0 = mem[idx];
    assign b1 = mem[idx + IdxWidth'(1)];
    assign b2 = mem[idx + IdxWidth'(2)];
    assign b3 = mem[idx + IdxWidth'(3)];

    always_comb begin
        case (memReq.size)
            One: begin
                loadValue = memReq.isSigned ? {{(DataWidth - 8){b0[7]}}, b0}
                                            : {{(DataWidth - 8){1'b0}}, b0};
            end
            Two: begin
                loadValue = memReq.isSigned ? {{(DataWidth - 16){b1[7]}}, b1, b0}
                                            : {{(DataWidth - 16){1'b0}}, b1, b0};
            end
            default: loadValue = {b3, b2, b1, b0};
        endcase
    end

    // sized write, upper bytes only for the wider accesses
    always_ff @(posedge clk) begin
        if (memReq.valid && memReq.isStore) begin
            mem[idx] <= memReq.data[7:0];
            if (memReq.size != One) begin
                mem[idx + IdxWidth'(1)] <= memReq.data[15:8];
            end
            if (memReq.size == Four) begin
                mem[idx + IdxWidth'(2)] <= memReq.data[23:16];
                mem[idx + IdxWidth'(3)] <= memReq.data[31:24];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            memResp.valid <= 1'b0;
        end else begin
            memResp.valid <= memReq.valid;
        end
        memResp.isStore <= memReq.isStore;
        memResp.tag     <= memReq.tag;
        memResp.data    <= memReq.isStore ? '0 : loadValue;
    end

    alignedAccess: assert property (
        @(posedge clk) disable iff (rst)
        memReq.valid |-> (memReq.size != Two  || memReq.addr[0] == 1'b0) &&
                         (memReq.size != Four || memReq.addr[1:0] == 2'b00)
    );

endmodule

//--- source/lsqIssue.sv
`timescale 1ns/1ps

module lsqIssue
    import rvIsaPkg::*, lsqPkg::*;
#(
    parameter int NumEntries = lsqPkg::NumEntries
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  entryStateT            states [NumEntries],
    input  logic                  commitValid,
    input  tagT                   commitTag,
    output logic [NumEntries-1:0] grant,
    output memReqT                memReq
);

    entryStateT commitEntry;
    entryStateT sel;
    logic       storeHit;
    logic       loadHit;
    tagT        loadTag;
    tagT        selTag;
    memReqT     reqNext;

    // store named by the reorder buffer once both operands are in
    always_comb begin
        commitEntry = states[commitTag];
        storeHit    = commitValid && commitEntry.occupied && !commitEntry.issued &&
                      opIsStore(commitEntry.op) &&
                      commitEntry.rs1.ready && commitEntry.rs2.ready;
    end

    // scan downward so the lowest ready index wins
    always_comb begin
        loadHit = 1'b0;
        loadTag = '0;
        for (int i = NumEntries - 1; i >= 0; i--) begin
            if (states[i].occupied && !states[i].issued &&
                opIsLoad(states[i].op) && states[i].rs1.ready) begin
                loadHit = 1'b1;
                loadTag = tagT'(i);
            end
        end
    end

    assign selTag = storeHit ? commitTag : loadTag;
    assign sel    = states[selTag];

    always_comb begin
        grant = '0;
        if (storeHit || loadHit) begin
            grant[selTag] = 1'b1;
        end
    end

    always_comb begin
        reqNext.valid    = storeHit || loadHit;
        reqNext.isStore  = storeHit;
        reqNext.tag      = selTag;
        reqNext.size     = opSize(sel.op);
        reqNext.isSigned = opSigned(sel.op);
        reqNext.addr     = sel.rs1.value + sel.imm;
        reqNext.data     = storeHit ? sel.rs2.value : '0;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            memReq.valid <= 1'b0;
        end else begin
            memReq <= reqNext;
        end
    end

    // the reorder buffer commits only stores that are waiting with both operands in
    commitNamesReadyStore: assert property (
        @(posedge clk) disable iff (rst)
        commitValid |-> storeHit
    );

endmodule

//--- source/lsqEntry.sv
`timescale 1ns/1ps

module lsqEntry
    import lsqPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       writeEn,
    input  logic       issueGrant,
    input  logic       free,
    input  dispatchT   entryIn,
    input  broadcastT  exBroadcast,
    input  broadcastT  loadResult,
    output entryStateT state
);

    // capture a value from either result bus when the tag matches
    function automatic operandT wake(operandT opnd, broadcastT bcA, broadcastT bcB);
        operandT res;
        res = opnd;
        if (!opnd.ready) begin
            if (bcA.valid && bcA.tag == opnd.tag) begin
                res.ready = 1'b1;
                res.value = bcA.value;
            end else if (bcB.valid && bcB.tag == opnd.tag) begin
                res.ready = 1'b1;
                res.value = bcB.value;
            end
        end
        return res;
    endfunction

    operandT rs1Next;
    operandT rs2Next;

    // a broadcast in the dispatch cycle is caught on the incoming operand
    always_comb begin
        if (writeEn) begin
            rs1Next = wake(entryIn.rs1, exBroadcast, loadResult);
            rs2Next = wake(entryIn.rs2, exBroadcast, loadResult);
        end else begin
            rs1Next = wake(state.rs1, exBroadcast, loadResult);
            rs2Next = wake(state.rs2, exBroadcast, loadResult);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush || free) begin
            state.occupied <= 1'b0;
            state.issued   <= 1'b0;
        end else if (writeEn) begin
            state.occupied <= 1'b1;
            state.issued   <= 1'b0;
        end else if (issueGrant) begin
            state.issued <= 1'b1;
        end
    end

    // instruction payload and operands
    always_ff @(posedge clk) begin
        if (writeEn) begin
            state.op  <= entryIn.op;
            state.imm <= entryIn.imm;
        end
        state.rs1 <= rs1Next;
        state.rs2 <= rs2Next;
    end

    // lsqIssue only looks at occupied, not yet issued slots
    grantNeedsOccupied: assert property (
        @(posedge clk) disable iff (rst)
        issueGrant |-> state.occupied
    );

endmodule

//--- source/lsqDispatch.sv
`timescale 1ns/1ps

module lsqDispatch
    import rvIsaPkg::*, lsqPkg::*;
#(
    parameter int NumEntries = lsqPkg::NumEntries
) (
    input  logic                  clk,
    input  logic                  rst,
    input  dispatchT              dispatch,
    input  logic [NumEntries-1:0] occupiedVec,
    output logic [NumEntries-1:0] writeEn,
    output dispatchT              entryIn,
    output logic                  full
);

    logic isLoad;
    logic isMemOp;

    assign isLoad  = opIsLoad(dispatch.op);
    assign isMemOp = dispatch.valid && (isLoad || opIsStore(dispatch.op));

    // the destination tag names the slot directly
    always_comb begin
        writeEn = '0;
        if (isMemOp) begin
            writeEn[dispatch.rdTag] = 1'b1;
        end
    end

    // loads never read rs2, so it is marked present up front
    always_comb begin
        entryIn       = dispatch;
        entryIn.valid = isMemOp;
        if (isLoad) begin
            entryIn.rs2.ready = 1'b1;
            entryIn.rs2.value = '0;
        end
    end

    assign full = &occupiedVec;

    // the producer must hold off while the tag is still in use
    noWriteToOccupied: assert property (
        @(posedge clk) disable iff (rst)
        (writeEn & occupiedVec) == '0
    );

endmodule

//--- source/lsqPkg.sv
package lsqPkg;

    import rvIsaPkg::*;

    // default slot count, one slot per reorder tag
    localparam int NumEntries = 8;
    localparam int TagWidth   = $clog2(NumEntries);

    typedef logic [TagWidth-1:0] tagT;

    // a source operand, either present or waiting on a tag
    typedef struct packed {
        logic                 ready;
        tagT                  tag;
        logic [DataWidth-1:0] value;
    } operandT;

    typedef struct packed {
        logic                 valid;
        memOpT                op;
        logic [DataWidth-1:0] imm;
        tagT                  rdTag;
        operandT              rs1;
        operandT              rs2;
    } dispatchT;

    typedef struct packed {
        logic                 valid;
        tagT                  tag;
        logic [DataWidth-1:0] value;
    } broadcastT;

    typedef struct packed {
        logic                 occupied;
        logic                 issued;
        memOpT                op;
        logic [DataWidth-1:0] imm;
        operandT              rs1;
        operandT              rs2;
    } entryStateT;

    typedef struct packed {
        logic                 valid;
        logic                 isStore;
        tagT                  tag;
        accessSizeT           size;
        logic                 isSigned;
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] data;
    } memReqT;

    typedef struct packed {
        logic                 valid;
        logic                 isStore;
        tagT                  tag;
        logic [DataWidth-1:0] data;
    } memRespT;

endpackage

//--- source/rvIsaPkg.sv
package rvIsaPkg;

    localparam int DataWidth = 32;
    localparam int AddrWidth = 32;

    // OTHER stands for any op that does not touch memory
    typedef enum logic [3:0] {
        LB, LH, LW, LBU, LHU, SB, SH, SW, OTHER
    } memOpT;

    typedef enum logic [1:0] {
        One, Two, Four
    } accessSizeT;

    function automatic logic opIsLoad(memOpT op);
        return op inside {LB, LH, LW, LBU, LHU};
    endfunction

    function automatic logic opIsStore(memOpT op);
        return op inside {SB, SH, SW};
    endfunction

    function automatic accessSizeT opSize(memOpT op);
        case (op)
            LB, LBU, SB: return One;
            LH, LHU, SH: return Two;
            default:     return Four;
        endcase
    endfunction

    // only the narrow loads without U extend the sign bit
    function automatic logic opSigned(memOpT op);
        return op inside {LB, LH};
    endfunction

endpackage
